//--- all.f
design/csr_pkg.sv
design/vcsr_map.sv
design/csr_reg.sv
design/csr_read_mux.sv
design/csr_file.sv
sim/csr_file_properties.sv
sim/csr_file_tb.sv

//--- Makefile
# Verilator build and run of the CSR file testbench

.PHONY: sim clean

sim:
	verilator --binary --assert -f all.f --top-module csr_file_tb -Mdir obj_dir
	./obj_dir/Vcsr_file_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/csr_file_tb.sv
/*
  Testbench for the machine-mode CSR file.
  Builds a table of directed and random requests, fills in the expected
  results from a reference model, then applies one entry per cycle and
  compares rdata, illegal, pend and mtvec.
*/
module csr_file_tb;

  localparam csr_pkg::word mtvec_reset = 32'h0000_0100;
  localparam csr_pkg::word hart_id     = 32'd3;
  localparam int           n_random    = 40;

  // one table row, stimulus followed by the expected results
  typedef struct packed {
    csr_pkg::csr_req_t req;
    logic [15:0]       pend_in;
    logic              pend_write;
    csr_pkg::word      exp_rdata;
    logic              exp_illegal;
    csr_pkg::word      exp_pend;
    csr_pkg::word      exp_mtvec;
  } entry_t;

  logic              clk;
  logic              reset;
  csr_pkg::csr_req_t req;
  logic [15:0]       pend_in;
  logic              pend_write;
  csr_pkg::word      rdata;
  logic              illegal;
  csr_pkg::word      pend;
  csr_pkg::word      mtvec;

  entry_t            stim_q [$];
  csr_pkg::word      m_mstatus;
  csr_pkg::word      m_mtvec;
  csr_pkg::word      m_mscratch;
  logic [15:0]       m_mip;
  int                word_errors;
  int                flag_errors;
  int                checks;
  int                cycle_limit;
  int                cycles;

  csr_file #(
    .mtvec_reset (mtvec_reset),
    .hart_id     (hart_id)
  ) i_dut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .pend_in    (pend_in),
    .pend_write (pend_write),
    .rdata      (rdata),
    .illegal    (illegal),
    .pend       (pend),
    .mtvec      (mtvec)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_entry(logic en, csr_pkg::csr_op_e op, csr_pkg::csr_addr_t addr,
                           csr_pkg::zimm_t zimm, csr_pkg::word rs1,
                           logic [15:0] pin, logic pw);
    entry_t e;
    e              = '0;
    e.req.enable   = en;
    e.req.op       = op;
    e.req.addr     = addr;
    e.req.zimm     = zimm;
    e.req.rs1_data = rs1;
    e.pend_in      = pin;
    e.pend_write   = pw;
    stim_q.push_back(e);
  endtask

  task automatic add_req(csr_pkg::csr_op_e op, csr_pkg::csr_addr_t addr,
                         csr_pkg::zimm_t zimm, csr_pkg::word rs1);
    add_entry(1'b1, op, addr, zimm, rs1, 16'h0, 1'b0);
  endtask

  // csrrs from x0 is a plain read
  task automatic add_read(csr_pkg::csr_addr_t addr);
    add_req(csr_pkg::csrrs, addr, 5'd0, 32'h0);
  endtask

  task automatic build_directed;
    // reset values
    add_read(csr_pkg::addr_mtvec);
    add_read(csr_pkg::addr_mhartid);
    add_read(csr_pkg::addr_mstatus);
    add_read(csr_pkg::addr_mscratch);
    add_read(csr_pkg::addr_mip);
    // full, set and clear on mscratch
    add_req(csr_pkg::csrrw, csr_pkg::addr_mscratch, 5'd5, 32'hDEAD_BEEF);
    add_req(csr_pkg::csrrs, csr_pkg::addr_mscratch, 5'd6, 32'h0000_0F00);
    add_req(csr_pkg::csrrc, csr_pkg::addr_mscratch, 5'd7, 32'hFFFF_0000);
    add_req(csr_pkg::csrrs, csr_pkg::addr_mscratch, 5'd0, 32'hFFFF_FFFF);
    add_req(csr_pkg::csrrc, csr_pkg::addr_mscratch, 5'd0, 32'hFFFF_FFFF);
    add_req(csr_pkg::csrrwi, csr_pkg::addr_mscratch, 5'h15, 32'hFFFF_FFFF);
    add_req(csr_pkg::csrrsi, csr_pkg::addr_mscratch, 5'h0A, 32'h0);
    add_req(csr_pkg::csrrci, csr_pkg::addr_mscratch, 5'h03, 32'h0);
    add_req(csr_pkg::csrrsi, csr_pkg::addr_mscratch, 5'h00, 32'h0);
    add_req(csr_pkg::csrrci, csr_pkg::addr_mscratch, 5'h00, 32'h0);
    add_read(csr_pkg::addr_mscratch);
    // bitfield views of mstatus and mip
    add_req(csr_pkg::csrrw, csr_pkg::addr_mstatus, 5'd1, 32'hA5A5_A5A0);
    add_req(csr_pkg::csrrwi, csr_pkg::addr_vcsr_mie, 5'd1, 32'h0);
    add_read(csr_pkg::addr_mstatus);
    add_req(csr_pkg::csrrc, csr_pkg::addr_vcsr_mie, 5'd0, 32'hFFFF_FFFF);
    add_read(csr_pkg::addr_mstatus);
    add_req(csr_pkg::csrrsi, csr_pkg::addr_vcsr_mie, 5'd1, 32'h0);
    add_req(csr_pkg::csrrw, csr_pkg::addr_mip, 5'd1, 32'h0000_5A3C);
    add_req(csr_pkg::csrrwi, csr_pkg::addr_vcsr_pend_hi, 5'h1F, 32'h0);
    add_read(csr_pkg::addr_mip);
    add_req(csr_pkg::csrrw, csr_pkg::addr_vcsr_pend_hi, 5'd2, 32'hFFFF_FF81);
    add_req(csr_pkg::csrrc, csr_pkg::addr_vcsr_pend_hi, 5'd0, 32'h0000_0001);
    add_read(csr_pkg::addr_mip);
    // pending lines against instruction writes
    add_entry(1'b1, csr_pkg::csrrw, csr_pkg::addr_mip, 5'd1, 32'h1234, 16'h00C3, 1'b1);
    add_read(csr_pkg::addr_mip);
    add_entry(1'b0, csr_pkg::csr_none, csr_pkg::addr_mip, 5'd0, 32'h0, 16'hA001, 1'b1);
    add_read(csr_pkg::addr_mip);
    add_req(csr_pkg::csrrw, csr_pkg::addr_mtvec, 5'd1, 32'h8000_0040);
    // illegal accesses
    add_req(csr_pkg::csrrw, 12'h123, 5'd1, 32'hFFFF_FFFF);
    add_req(csr_pkg::csrrw, csr_pkg::addr_mhartid, 5'd1, 32'h0000_FFFF);
    add_req(csr_pkg::csrrsi, csr_pkg::addr_mhartid, 5'd4, 32'h0);
    add_req(csr_pkg::csrrs, csr_pkg::addr_mhartid, 5'd0, 32'hFFFF_FFFF);
    add_entry(1'b0, csr_pkg::csrrw, 12'h123, 5'd1, 32'h0, 16'h0, 1'b0);
    add_read(csr_pkg::addr_mstatus);
    add_read(csr_pkg::addr_mtvec);
    add_read(csr_pkg::addr_mscratch);
    add_read(csr_pkg::addr_mip);
  endtask

  task automatic add_random;
    csr_pkg::csr_addr_t addrs [8];
    csr_pkg::csr_op_e   op;
    csr_pkg::zimm_t     zimm;
    logic [2:0]         pick;
    int                 i;
    addrs = '{csr_pkg::addr_mstatus, csr_pkg::addr_mtvec, csr_pkg::addr_mscratch,
              csr_pkg::addr_mip, csr_pkg::addr_mhartid, csr_pkg::addr_vcsr_mie,
              csr_pkg::addr_vcsr_pend_hi, 12'h123};
    for (i = 0; i < n_random; i++) begin
      case ($urandom % 7)
        0:       op = csr_pkg::csr_none;
        1:       op = csr_pkg::csrrw;
        2:       op = csr_pkg::csrrs;
        3:       op = csr_pkg::csrrc;
        4:       op = csr_pkg::csrrwi;
        5:       op = csr_pkg::csrrsi;
        default: op = csr_pkg::csrrci;
      endcase
      zimm = (($urandom % 3) == 0) ? 5'd0 : csr_pkg::zimm_t'($urandom);
      pick = 3'($urandom);
      add_entry(($urandom % 8) != 0, op, addrs[pick], zimm, $urandom,
                16'($urandom), ($urandom % 6) == 0);
    end
  endtask

  // reference write rules, a virtual access walks the field bit by bit
  function automatic csr_pkg::word apply_op(csr_pkg::word cur, csr_pkg::csr_req_t r,
                                            logic virt, int width, int offset);
    csr_pkg::word src;
    csr_pkg::word result;
    logic         is_imm;
    int           b;
    is_imm = (r.op == csr_pkg::csrrwi || r.op == csr_pkg::csrrsi ||
              r.op == csr_pkg::csrrci);
    src    = is_imm ? {27'b0, r.zimm} : r.rs1_data;
    result = cur;
    if (virt) begin
      for (b = 0; b < width; b++) begin
        case (r.op)
          csr_pkg::csrrw, csr_pkg::csrrwi: result[offset + b] = src[b];
          csr_pkg::csrrs, csr_pkg::csrrsi: result[offset + b] = cur[offset + b] | src[b];
          csr_pkg::csrrc, csr_pkg::csrrci: result[offset + b] = cur[offset + b] & ~src[b];
          default: ;
        endcase
      end
    end else begin
      // set and clear from x0 or a zero immediate leave the register alone
      case (r.op)
        csr_pkg::csrrw, csr_pkg::csrrwi: result = src;
        csr_pkg::csrrs, csr_pkg::csrrsi: result = (r.zimm != 5'd0) ? (cur | src) : cur;
        csr_pkg::csrrc, csr_pkg::csrrci: result = (r.zimm != 5'd0) ? (cur & ~src) : cur;
        default:                         result = cur;
      endcase
    end
    return result;
  endfunction

  // expected outputs for one entry, then the model commits the clock edge
  task automatic model_step(inout entry_t e);
    logic               virt;
    int                 width;
    int                 offset;
    csr_pkg::csr_addr_t eff;
    csr_pkg::word       old;
    csr_pkg::word       mip_new;
    logic               known;
    logic               writes;
    virt   = 1'b1;
    width  = 0;
    offset = 0;
    eff    = e.req.addr;
    case (e.req.addr)
      csr_pkg::addr_vcsr_mie: begin
        eff    = csr_pkg::addr_mstatus;
        width  = 1;
        offset = 3;
      end
      csr_pkg::addr_vcsr_pend_hi: begin
        eff    = csr_pkg::addr_mip;
        width  = 8;
        offset = 8;
      end
      default: virt = 1'b0;
    endcase
    known = 1'b1;
    case (eff)
      csr_pkg::addr_mstatus:  old = m_mstatus;
      csr_pkg::addr_mtvec:    old = m_mtvec;
      csr_pkg::addr_mscratch: old = m_mscratch;
      csr_pkg::addr_mip:      old = {16'h0, m_mip};
      csr_pkg::addr_mhartid:  old = hart_id;
      default: begin
        old   = '0;
        known = 1'b0;
      end
    endcase
    case (e.req.op)
      csr_pkg::csrrw, csr_pkg::csrrwi: writes = 1'b1;
      csr_pkg::csr_none:               writes = 1'b0;
      default:                         writes = (e.req.zimm != 5'd0);
    endcase
    e.exp_rdata   = old;
    e.exp_illegal = e.req.enable && (!known || (writes && eff == csr_pkg::addr_mhartid));
    e.exp_mtvec   = m_mtvec;
    mip_new       = {16'h0, m_mip};
    if (e.req.enable) begin
      case (eff)
        csr_pkg::addr_mstatus:  m_mstatus  = apply_op(m_mstatus, e.req, virt, width, offset);
        csr_pkg::addr_mtvec:    m_mtvec    = apply_op(m_mtvec, e.req, virt, width, offset);
        csr_pkg::addr_mscratch: m_mscratch = apply_op(m_mscratch, e.req, virt, width, offset);
        csr_pkg::addr_mip:      mip_new    = apply_op(mip_new, e.req, virt, width, offset);
        default: ;
      endcase
    end
    if (e.pend_write) begin
      mip_new = {16'h0, e.pend_in};
    end
    m_mip      = mip_new[15:0];
    e.exp_pend = {16'h0, m_mip};
  endtask

  task automatic fill_expected;
    entry_t e;
    int     i;
    m_mstatus  = '0;
    m_mtvec    = mtvec_reset;
    m_mscratch = '0;
    m_mip      = '0;
    for (i = 0; i < stim_q.size(); i++) begin
      e = stim_q[i];
      model_step(e);
      stim_q[i] = e;
    end
  endtask

  task automatic check_word(string name, csr_pkg::word got, csr_pkg::word exp);
    checks++;
    if (got !== exp) begin
      word_errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      flag_errors++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  initial begin
    reset       = 1'b1;
    req         = '0;
    pend_in     = '0;
    pend_write  = 1'b0;
    word_errors = 0;
    flag_errors = 0;
    checks      = 0;
    void'($urandom(77));
    build_directed();
    add_random();
    fill_expected();
    cycle_limit = stim_q.size() + 8 + 20;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    foreach (stim_q[i]) begin
      req        <= stim_q[i].req;
      pend_in    <= stim_q[i].pend_in;
      pend_write <= stim_q[i].pend_write;
      // outputs are settled mid-cycle
      @(negedge clk);
      check_word("rdata", rdata, stim_q[i].exp_rdata);
      check_flag("illegal", illegal, stim_q[i].exp_illegal);
      check_word("pend", pend, stim_q[i].exp_pend);
      check_word("mtvec", mtvec, stim_q[i].exp_mtvec);
      @(posedge clk);
    end
    req        <= '0;
    pend_write <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    $display("checks %0d, word errors %0d, flag errors %0d, assertion errors %0d",
             checks, word_errors, flag_errors, i_dut.i_props.fail_count);
    if (word_errors + flag_errors + i_dut.i_props.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // run limit from the table length plus reset and some slack
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the stimulus table did not complete", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim/csr_file_properties.sv
/*
  Concurrent assertions for the CSR file, bound into csr_file.
  Covers the idle illegal flag, the constant hart id and the mip load
  from the interrupt pending lines.
*/
module csr_file_properties (
  input logic         clk,
  input logic         reset,
  input logic         enable,
  input logic         illegal,
  input csr_pkg::word mhartid,
  input csr_pkg::word mip,
  input logic [15:0]  pend_in,
  input logic         pend_write
);

  // number of failed assertions
  int fail_count = 0;

  a_idle_legal: assert property (@(posedge clk) disable iff (reset) !enable |-> !illegal)
    else begin
      fail_count++;
      $error("illegal raised without an enabled request");
    end

  a_hartid_const: assert property (@(posedge clk) disable iff (reset) $stable(mhartid))
    else begin
      fail_count++;
      $error("mhartid changed");
    end

  // pending lines win, so mip always follows pend_in
  a_pend_load: assert property (@(posedge clk) disable iff (reset)
                                pend_write |=> (mip == {16'h0, $past(pend_in)}))
    else begin
      fail_count++;
      $error("mip does not hold the pending lines loaded the cycle before");
    end

endmodule

bind csr_file csr_file_properties i_props (
  .clk        (clk),
  .reset      (reset),
  .enable     (req.enable),
  .illegal    (illegal),
  .mhartid    (mhartid_val),
  .mip        (mip_val),
  .pend_in    (pend_in),
  .pend_write (pend_write)
);

//--- design/csr_file.sv
/*
  Machine-mode CSR file top level.
  Takes one decoded CSR request per cycle, returns the old value in the
  same cycle and commits the write at the next clock edge. mip can also
  be loaded from the interrupt pending lines.
*/
module csr_file #(
  parameter csr_pkg::word mtvec_reset = 32'h0000_0000,
  parameter csr_pkg::word hart_id     = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_req_t    req,
  input  logic [15:0]          pend_in,
  input  logic                 pend_write,
  output csr_pkg::word         rdata,
  output logic                 illegal,
  output csr_pkg::word         pend,
  output csr_pkg::word         mtvec
);

  csr_pkg::vcsr_field_t field;
  csr_pkg::word         mstatus_val;
  csr_pkg::word         mscratch_val;
  csr_pkg::word         mip_val;
  csr_pkg::word         mhartid_val;

  vcsr_map i_vcsr_map (
    .addr  (req.addr),
    .field (field)
  );

  csr_reg #(
    .csr_width   (32),
    .reset_value (32'h0),
    .addr        (csr_pkg::addr_mstatus),
    .readable    (1'b1),
    .writable    (1'b1)
  ) i_mstatus (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .field      (field),
    .ext_data   (32'h0),
    .ext_write  (1'b0),
    .value      (mstatus_val),
    .next_value ()
  );

  csr_reg #(
    .csr_width   (32),
    .reset_value (mtvec_reset),
    .addr        (csr_pkg::addr_mtvec),
    .readable    (1'b1),
    .writable    (1'b1)
  ) i_mtvec (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .field      (field),
    .ext_data   (32'h0),
    .ext_write  (1'b0),
    .value      (mtvec),
    .next_value ()
  );

  csr_reg #(
    .csr_width   (32),
    .reset_value (32'h0),
    .addr        (csr_pkg::addr_mscratch),
    .readable    (1'b1),
    .writable    (1'b1)
  ) i_mscratch (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .field      (field),
    .ext_data   (32'h0),
    .ext_write  (1'b0),
    .value      (mscratch_val),
    .next_value ()
  );

  // pending lines load mip directly, next value feeds the interrupt logic
  csr_reg #(
    .csr_width   (16),
    .reset_value (16'h0),
    .addr        (csr_pkg::addr_mip),
    .readable    (1'b1),
    .writable    (1'b1)
  ) i_mip (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .field      (field),
    .ext_data   (pend_in),
    .ext_write  (pend_write),
    .value      (mip_val),
    .next_value (pend)
  );

  csr_reg #(
    .csr_width   (32),
    .reset_value (hart_id),
    .addr        (csr_pkg::addr_mhartid),
    .readable    (1'b1),
    .writable    (1'b0)
  ) i_mhartid (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .field      (field),
    .ext_data   (32'h0),
    .ext_write  (1'b0),
    .value      (mhartid_val),
    .next_value ()
  );

  csr_read_mux i_read_mux (
    .req      (req),
    .field    (field),
    .mstatus  (mstatus_val),
    .mtvec    (mtvec),
    .mscratch (mscratch_val),
    .mip      (mip_val),
    .mhartid  (mhartid_val),
    .rdata    (rdata),
    .illegal  (illegal)
  );

endmodule

//--- design/csr_read_mux.sv
/*
  Read side of the CSR file.
  Picks the old value of the addressed register, following a virtual
  address to its target, and flags unknown addresses and writes to the
  read-only hart id.
*/
module csr_read_mux (
  input  csr_pkg::csr_req_t    req,
  input  csr_pkg::vcsr_field_t field,
  input  csr_pkg::word         mstatus,
  input  csr_pkg::word         mtvec,
  input  csr_pkg::word         mscratch,
  input  csr_pkg::word         mip,
  input  csr_pkg::word         mhartid,
  output csr_pkg::word         rdata,
  output logic                 illegal
);

  csr_pkg::csr_addr_t eff_addr;
  logic               known;
  logic               is_write;

  assign eff_addr = field.hit ? field.target : req.addr;

  always_comb begin
    known = 1'b1;
    case (eff_addr)
      csr_pkg::addr_mstatus:  rdata = mstatus;
      csr_pkg::addr_mtvec:    rdata = mtvec;
      csr_pkg::addr_mscratch: rdata = mscratch;
      csr_pkg::addr_mip:      rdata = mip;
      csr_pkg::addr_mhartid:  rdata = mhartid;
      default: begin
        rdata = '0;
        known = 1'b0;
      end
    endcase
  end

  // set and clear with a zero source are plain reads
  always_comb begin
    case (req.op)
      csr_pkg::csrrw, csr_pkg::csrrwi: is_write = 1'b1;
      csr_pkg::csrrs, csr_pkg::csrrc,
      csr_pkg::csrrsi, csr_pkg::csrrci: is_write = (req.zimm != '0);
      default: is_write = 1'b0;
    endcase
  end

  assign illegal = req.enable &&
                   (!known || (is_write && eff_addr == csr_pkg::addr_mhartid));

endmodule

//--- design/csr_reg.sv
/*
  One control and status register.
  Handles full, set and clear writes on its own address, bitfield writes
  arriving through a virtual address, and an external load port that
  overrides instruction writes. The old value is read combinationally.
*/
module csr_reg #(
  parameter int unsigned             csr_width   = 32,
  parameter logic [csr_width-1:0]    reset_value = '0,
  parameter csr_pkg::csr_addr_t      addr        = 12'h000,
  parameter bit                      readable    = 1'b1,
  parameter bit                      writable    = 1'b1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  csr_pkg::csr_req_t      req,
  input  csr_pkg::vcsr_field_t   field,
  input  logic [csr_width-1:0]   ext_data,
  input  logic                   ext_write,
  output csr_pkg::word           value,
  output csr_pkg::word           next_value
);

  logic [csr_width-1:0] data;
  logic [csr_width-1:0] nxt_data;
  logic                 direct_hit;
  logic                 virt_hit;
  logic                 write_op;
  logic                 set_op;
  logic                 clear_op;
  logic                 imm_op;
  logic                 suppress;
  csr_pkg::word         cur;
  csr_pkg::word         src;
  csr_pkg::word         operand;
  csr_pkg::word         wmask;
  csr_pkg::word         upd;

  assign direct_hit = req.enable && !field.hit && (req.addr == addr);
  assign virt_hit   = req.enable && field.hit && (field.target == addr);

  // split the op into its kind and its source
  always_comb begin
    write_op = 1'b0;
    set_op   = 1'b0;
    clear_op = 1'b0;
    imm_op   = 1'b0;
    case (req.op)
      csr_pkg::csrrw:  write_op = 1'b1;
      csr_pkg::csrrs:  set_op   = 1'b1;
      csr_pkg::csrrc:  clear_op = 1'b1;
      csr_pkg::csrrwi: begin
        write_op = 1'b1;
        imm_op   = 1'b1;
      end
      csr_pkg::csrrsi: begin
        set_op = 1'b1;
        imm_op = 1'b1;
      end
      csr_pkg::csrrci: begin
        clear_op = 1'b1;
        imm_op   = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    cur = csr_pkg::word'(data);
    src = imm_op ? csr_pkg::word'(req.zimm) : req.rs1_data;
    // direct access touches every bit, x0 / zero imm suppresses set and clear
    operand  = src;
    wmask    = '1;
    suppress = (req.zimm == '0);
    if (virt_hit) begin
      wmask    = ((csr_pkg::word'(1) << field.width) - csr_pkg::word'(1)) << field.offset;
      operand  = (src << field.offset) & wmask;
      suppress = 1'b0;
    end
    upd = cur;
    if (write_op) begin
      upd = (cur & ~wmask) | operand;
    end else if (set_op && !suppress) begin
      upd = cur | operand;
    end else if (clear_op && !suppress) begin
      upd = cur & ~operand;
    end
  end

  // external load wins over the instruction
  always_comb begin
    if (ext_write) begin
      nxt_data = ext_data;
    end else if (writable && (direct_hit || virt_hit)) begin
      nxt_data = upd[csr_width-1:0];
    end else begin
      nxt_data = data;
    end
  end

  if (writable) begin : g_rw
    always_ff @(posedge clk) begin
      if (reset) begin
        data <= reset_value;
      end else begin
        data <= nxt_data;
      end
    end
  end else begin : g_ro
    // read-only registers hold their constant
    assign data = reset_value;
  end

  assign value      = readable ? csr_pkg::word'(data) : '0;
  assign next_value = csr_pkg::word'(nxt_data);

endmodule

//--- design/vcsr_map.sv
/*
  Virtual CSR lookup table.
  Turns a virtual CSR address into the physical target address and the
  width and offset of the field it exposes. hit is low for all other
  addresses.
*/
module vcsr_map (
  input  csr_pkg::csr_addr_t   addr,
  output csr_pkg::vcsr_field_t field
);

  always_comb begin
    field = '0;
    case (addr)
      // global interrupt enable, mstatus.mie
      csr_pkg::addr_vcsr_mie: begin
        field.hit    = 1'b1;
        field.target = csr_pkg::addr_mstatus;
        field.width  = 5'd1;
        field.offset = 5'd3;
      end
      // upper pending byte of mip
      csr_pkg::addr_vcsr_pend_hi: begin
        field.hit    = 1'b1;
        field.target = csr_pkg::addr_mip;
        field.width  = 5'd8;
        field.offset = 5'd8;
      end
      default: field = '0;
    endcase
  end

endmodule

//--- design/csr_pkg.sv
/*
  Shared types for the machine-mode CSR file.
  Holds the data and address types, the CSR operation enum, the decoded
  request and virtual field structs, and the CSR address map.
  Every design file refers to these by scoped names.
*/
package csr_pkg;

  // basic data and address types
  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  zimm_t;

  // bitfield description for virtual CSRs
  typedef logic [4:0] field_width_t;
  typedef logic [4:0] field_offset_t;

  // encoded as the funct3 field, csr_none takes the unused zero slot
  typedef enum logic [2:0] {
    csr_none = 3'b000,
    csrrw    = 3'b001,
    csrrs    = 3'b010,
    csrrc    = 3'b011,
    csrrwi   = 3'b101,
    csrrsi   = 3'b110,
    csrrci   = 3'b111
  } csr_op_e;

  // one decoded CSR instruction
  typedef struct packed {
    logic      enable;
    csr_op_e   op;
    csr_addr_t addr;
    zimm_t     zimm;
    word       rs1_data;
  } csr_req_t;

  // result of the virtual address lookup
  typedef struct packed {
    logic          hit;
    csr_addr_t     target;
    field_width_t  width;
    field_offset_t offset;
  } vcsr_field_t;

  // physical registers
  localparam csr_addr_t addr_mstatus  = 12'h300;
  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'h340;
  localparam csr_addr_t addr_mip      = 12'h344;
  localparam csr_addr_t addr_mhartid  = 12'hF14;

  // virtual bitfield views, custom machine read/write range
  localparam csr_addr_t addr_vcsr_mie     = 12'h7C0;
  localparam csr_addr_t addr_vcsr_pend_hi = 12'h7C1;

endpackage
